// File: nabp_image.f
verilog/nabp_pkg.sv
verilog/pe_stream_register.sv
verilog/image_addresser.sv
verilog/image_accumulator.sv
verilog/nabp_image_top.sv
testbench/nabp_image_assert.sv
testbench/nabp_image_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the nabp_image testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert \
        --top-module nabp_image_tb \
        -f nabp_image.f \
        -Mdir obj_dir -o nabp_image_sim; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/nabp_image_sim > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^=== PASS ===$" "$log"; then
    exit 0
fi
echo "pass line not found in $log"
exit 1

// File: testbench/nabp_image_trace.txt
// words 0 to 31: PE values in beat order (x then y scan per partition)
// words 32 to 47: expected pixel per image address after one sweep
0111 0222 0333 0444 0555 0666 0777 0888
0999 0AAA 0BBB 0CCC 0DDD 0EEE 0FFF 1110
1221 1332 1443 1554 1665 1776 1887 1998
1AA9 1BBA 1CCB 1DDC 1EED 1FFE 210F 2220
// expected image, addresses 0 to 15
0AAA 0FFF 1DDC 2331 0FFF 1554 2331 2886
1DDC 2331 310E 3663 2331 2886 3663 3BB8

// File: testbench/nabp_image_tb.sv
`default_nettype none

module nabp_image_tb;

    localparam int image_size     = 4;
    localparam int partition_size = 2;
    localparam int settle_delay   = 3;
    localparam int words          = image_size * image_size;
    localparam int addr_w         = $clog2(words);
    localparam int beats          = 2 * words;

    logic                clk;
    logic                reset_n;
    logic                kick;
    logic                pe_enable;
    nabp_pkg::pe_value_t pe_value;
    logic [addr_w-1:0]   rd_addr;
    nabp_pkg::pixel_t    rd_data;
    logic                busy;

    // PE values first, expected image after them
    nabp_pkg::pixel_t trace_mem [0:beats+words-1];

    logic [31:0] lfsr_state;
    int          errors;
    int          errors_at_start;
    int          tests_run;
    int          tests_failed;
    int          trace_fd;
    bit          timed_out;

    nabp_image_top
    #(
        .image_size     (image_size),
        .partition_size (partition_size),
        .settle_delay   (settle_delay)
    )
    UUT
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .kick      (kick),
        .pe_enable (pe_enable),
        .pe_value  (pe_value),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .busy      (busy)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 32'h80200003;
        return n;
    endfunction

    // one LFSR step per bit
    task automatic random_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++)
        begin
            value      = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic wait_busy_low(input int limit);
        int  count;
        logic done;
        count = 0;
        done  = 1'b0;
        while (!done && count < limit)
        begin
            @(negedge clk);
            count++;
            if (!busy)
                done = 1'b1;
        end
        if (!done)
        begin
            $display("timeout: busy still high after %0d cycles", limit);
            timed_out = 1'b1;
        end
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles)
        begin
            @(negedge clk);
            check_value("busy while idle", 32'(busy), 32'd0);
        end
    endtask

    // registered read, data one edge after the address
    task automatic check_image(input int mult, input string what);
        logic [31:0] expected;
        for (int a = 0; a < words; a++)
        begin
            @(posedge clk);
            rd_addr <= addr_w'(a);
            @(posedge clk);
            @(negedge clk);
            expected = 32'(trace_mem[beats + a]) * 32'(mult);
            check_value($sformatf("%s pixel %0d", what, a), 32'(rd_data), expected);
        end
    endtask

    task automatic run_sweep(input bit use_gaps, input bit zero_values, input bit kick_mid);
        int gap;
        @(posedge clk);
        kick <= 1'b1;
        @(posedge clk);
        kick <= 1'b0;
        // stream register plus settle delay before beats count
        repeat (settle_delay) @(posedge clk);
        for (int k = 0; k < beats; k++)
        begin
            if (kick_mid && k == beats / 2)
            begin
                @(posedge clk);
                pe_enable <= 1'b0;
                kick      <= 1'b1;
            end
            @(posedge clk);
            kick      <= 1'b0;
            pe_enable <= 1'b1;
            pe_value  <= zero_values ? 16'h0 : 16'(trace_mem[k]);
            gap = 0;
            if (use_gaps)
                random_bits(2, gap);
            repeat (gap)
            begin
                @(posedge clk);
                pe_enable <= 1'b0;
            end
        end
        @(posedge clk);
        pe_enable <= 1'b0;
    endtask

    task automatic finish_test(input int num, input string name);
        tests_run++;
        if (errors == errors_at_start)
            $display("test %0d %s: passed", num, name);
        else
        begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", num, name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    task automatic run_tests();
        repeat (4) @(posedge clk);
        reset_n <= 1'b0;

        wait_busy_low(words + 8);
        if (timed_out)
            return;
        check_image(0, "after reset");
        finish_test(1, "reset clear");

        run_sweep(1'b0, 1'b0, 1'b0);
        wait_busy_low(beats * 5 + 20);
        if (timed_out)
            return;
        check_image(1, "first sweep");
        finish_test(2, "sweep without gaps");

        run_sweep(1'b1, 1'b0, 1'b0);
        wait_busy_low(beats * 5 + 20);
        if (timed_out)
            return;
        check_image(2, "second sweep");
        finish_test(3, "sweep with gaps");

        // kick together with an enable is suppressed, idle enables dropped
        @(posedge clk);
        kick      <= 1'b1;
        pe_enable <= 1'b1;
        pe_value  <= 16'hffff;
        @(posedge clk);
        kick <= 1'b0;
        repeat (3) @(posedge clk);
        pe_enable <= 1'b0;
        check_idle(settle_delay + 4);
        check_image(2, "idle enables");
        finish_test(4, "idle kick and enables");

        run_sweep(1'b1, 1'b1, 1'b1);
        wait_busy_low(beats * 5 + 20);
        if (timed_out)
            return;
        check_idle(settle_delay + 4);
        check_image(2, "kick during sweep");
        finish_test(5, "kick during sweep");
    endtask

    initial
    begin
        clk             = 1'b0;
        reset_n         = 1'b1;
        kick            = 1'b0;
        pe_enable       = 1'b0;
        pe_value        = '0;
        rd_addr         = '0;
        lfsr_state      = 32'hefd83d30;
        errors          = 0;
        errors_at_start = 0;
        tests_run       = 0;
        tests_failed    = 0;
        timed_out       = 1'b0;
        trace_fd        = $fopen("testbench/nabp_image_trace.txt", "r");
        if (trace_fd == 0)
        begin
            $display("trace file testbench/nabp_image_trace.txt could not be opened");
            $display("=== FAIL ===");
            $finish;
        end
        else
        begin
            $fclose(trace_fd);
            $readmemh("testbench/nabp_image_trace.txt", trace_mem);
            run_tests();
            $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
            if (errors == 0 && !timed_out)
                $display("=== PASS ===");
            else
                $display("=== FAIL ===");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: testbench/nabp_image_assert.sv
`default_nettype none

module nabp_image_assert
#(
    parameter int image_size = 4
)
(
    input wire                                      clk,
    input wire                                      reset_n,
    input wire nabp_pkg::addresser_state_t          state,
    input wire [$clog2(image_size*image_size)-1:0]  ir_addr,
    input wire                                      ir_valid,
    input wire                                      sweep_active,
    input wire                                      advance,
    input wire                                      scan_done
);

    localparam int words  = image_size * image_size;
    localparam int addr_w = $clog2(words);

    logic [addr_w-1:0] prev_addr;
    logic              in_line;

    // last x address, valid while the next beat stays in the same line
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            prev_addr <= '0;
            in_line   <= 1'b0;
        end
        else if (advance && state == nabp_pkg::addressing_x)
        begin
            prev_addr <= ir_addr;
            in_line   <= !scan_done;
        end
        else if (state != nabp_pkg::addressing_x)
        begin
            in_line <= 1'b0;
        end
    end

    addr_in_range: assert property (@(posedge clk) disable iff (reset_n)
        ir_valid |-> int'(ir_addr) < words)
        else $error("image address %0d outside the image", ir_addr);

    idle_after_reset: assert property (@(posedge clk)
        reset_n |=> !sweep_active)
        else $error("sweep active right after reset");

    x_scan_step: assert property (@(posedge clk) disable iff (reset_n)
        (state == nabp_pkg::addressing_x && advance && in_line)
            |-> ir_addr == addr_w'(prev_addr + 1'b1))
        else $error("x scan address did not step by one");

endmodule

bind image_addresser nabp_image_assert
#(
    .image_size (image_size)
)
u_assert
(
    .clk          (clk),
    .reset_n      (reset_n),
    .state        (state),
    .ir_addr      (ir_addr),
    .ir_valid     (ir_valid),
    .sweep_active (sweep_active),
    .advance      (advance),
    .scan_done    (scan_done)
);

`default_nettype wire

// File: verilog/nabp_image_top.sv
`default_nettype none

module nabp_image_top
#(
    parameter int image_size     = 4,
    parameter int partition_size = 2,
    parameter int settle_delay   = 3
)
(
    input  wire                                      clk,
    input  wire                                      reset_n,
    input  wire                                      kick,
    input  wire                                      pe_enable,
    input  wire nabp_pkg::pe_value_t                 pe_value,
    input  wire [$clog2(image_size*image_size)-1:0]  rd_addr,
    output nabp_pkg::pixel_t                         rd_data,
    output logic                                     busy
);

    localparam int addr_w = $clog2(image_size * image_size);

    nabp_pkg::pe_beat_t beat;

    logic [addr_w-1:0] ir_addr;
    logic              ir_valid;
    logic              sweep_active;
    logic              clearing;

    pe_stream_register u_stream
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .kick      (kick),
        .pe_enable (pe_enable),
        .pe_value  (pe_value),
        .beat      (beat)
    );

    image_addresser
    #(
        .image_size     (image_size),
        .partition_size (partition_size),
        .settle_delay   (settle_delay)
    )
    u_addresser
    (
        .clk          (clk),
        .reset_n      (reset_n),
        .beat         (beat),
        .ir_addr      (ir_addr),
        .ir_valid     (ir_valid),
        .sweep_active (sweep_active)
    );

    image_accumulator
    #(
        .image_size (image_size)
    )
    u_accumulator
    (
        .clk      (clk),
        .reset_n  (reset_n),
        .beat     (beat),
        .ir_addr  (ir_addr),
        .ir_valid (ir_valid),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .clearing (clearing)
    );

    assign busy = sweep_active | clearing;

endmodule

`default_nettype wire

// File: verilog/image_accumulator.sv
`default_nettype none

module image_accumulator
#(
    parameter int image_size = 4
)
(
    input  wire                                      clk,
    input  wire                                      reset_n,
    input  wire nabp_pkg::pe_beat_t                  beat,
    input  wire [$clog2(image_size*image_size)-1:0]  ir_addr,
    input  wire                                      ir_valid,
    input  wire [$clog2(image_size*image_size)-1:0]  rd_addr,
    output nabp_pkg::pixel_t                         rd_data,
    output logic                                     clearing
);

    localparam int addr_w = $clog2(image_size * image_size);
    localparam int words  = image_size * image_size;

    nabp_pkg::pixel_t mem [words];

    logic [addr_w-1:0] clear_addr;
    logic              clear_last;
    logic              acc_en;

    assign clear_last = (clear_addr == addr_w'(words - 1));

    // beats outside addressing are dropped
    assign acc_en = beat.enable && ir_valid;

    // clear walk, one word per cycle after reset
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            clearing   <= 1'b1;
            clear_addr <= '0;
        end
        else if (clearing)
        begin
            clear_addr <= clear_addr + 1'b1;
            if (clear_last)
                clearing <= 1'b0;
        end
    end

    // read-modify-write in a single cycle
    // the clear walk wins over any beat
    always_ff @(posedge clk)
    begin
        if (clearing)
            mem[clear_addr] <= '0;
        else if (acc_en)
            mem[ir_addr] <= mem[ir_addr] + nabp_pkg::pixel_t'(beat.value);
    end

    always_ff @(posedge clk)
    begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: verilog/image_addresser.sv
`default_nettype none

module image_addresser
#(
    parameter int image_size     = 4,
    parameter int partition_size = 2,
    parameter int settle_delay   = 3
)
(
    input  wire                                      clk,
    input  wire                                      reset_n,
    input  wire nabp_pkg::pe_beat_t                  beat,
    output logic [$clog2(image_size*image_size)-1:0] ir_addr,
    output logic                                     ir_valid,
    output logic                                     sweep_active
);

    localparam int addr_w    = $clog2(image_size * image_size);
    localparam int num_parts = image_size / partition_size;
    localparam int scan_w    = (image_size > 1) ? $clog2(image_size) : 1;
    localparam int line_w    = (partition_size > 1) ? $clog2(partition_size) : 1;
    localparam int part_w    = (num_parts > 1) ? $clog2(num_parts) : 1;
    localparam int delay_w   = (settle_delay > 1) ? $clog2(settle_delay) : 1;

    localparam logic [addr_w-1:0] row_step  = addr_w'(image_size);
    localparam logic [addr_w-1:0] part_step = addr_w'(partition_size * image_size);
    localparam logic [addr_w-1:0] col_step  = addr_w'(partition_size);

    nabp_pkg::addresser_state_t state;
    nabp_pkg::addresser_state_t next_state;

    logic [scan_w-1:0]  scan_pos;
    logic [line_w-1:0]  line_pos;
    logic [part_w-1:0]  part_idx;
    logic [delay_w-1:0] delay_cnt;
    logic [addr_w-1:0]  x_off;
    logic [addr_w-1:0]  y_off;
    logic [addr_w-1:0]  x_addr;
    logic [addr_w-1:0]  y_addr;

    logic scan_done;
    logic line_done;
    logic part_done;
    logic delay_done;
    logic advance;

    assign scan_done  = (scan_pos == scan_w'(image_size - 1));
    assign line_done  = (line_pos == line_w'(partition_size - 1));
    assign part_done  = (part_idx == part_w'(num_parts - 1));
    assign delay_done = (delay_cnt == delay_w'(settle_delay - 1));

    assign ir_valid = (state == nabp_pkg::addressing_x) ||
                      (state == nabp_pkg::addressing_y);
    assign advance  = ir_valid && beat.enable;

    // row-major inside the partition for x, column-major for y
    assign x_addr = x_off + addr_w'(line_pos) * row_step + addr_w'(scan_pos);
    assign y_addr = y_off + addr_w'(line_pos) + addr_w'(scan_pos) * row_step;

    assign ir_addr      = (state == nabp_pkg::addressing_y) ? y_addr : x_addr;
    assign sweep_active = (state != nabp_pkg::ready);

    always_comb
    begin
        next_state = state;
        case (state)
            nabp_pkg::ready:
                if (beat.kick)
                    next_state = nabp_pkg::delay;
            nabp_pkg::delay:
                if (delay_done)
                    next_state = nabp_pkg::addressing_x;
            nabp_pkg::addressing_x:
                if (advance && scan_done && line_done)
                    next_state = nabp_pkg::addressing_y;
            nabp_pkg::addressing_y:
                if (advance && scan_done && line_done)
                    next_state = part_done ? nabp_pkg::ready : nabp_pkg::addressing_x;
            default:
                next_state = nabp_pkg::ready;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset_n)
            state <= nabp_pkg::ready;
        else
            state <= next_state;
    end

    always_ff @(posedge clk)
    begin
        if (reset_n || state == nabp_pkg::ready)
        begin
            delay_cnt <= '0;
            scan_pos  <= '0;
            line_pos  <= '0;
            part_idx  <= '0;
            x_off     <= '0;
            y_off     <= '0;
        end
        else if (state == nabp_pkg::delay)
        begin
            delay_cnt <= delay_cnt + 1'b1;
        end
        else if (advance)
        begin
            scan_pos <= scan_done ? '0 : scan_pos + 1'b1;
            if (scan_done)
                line_pos <= line_done ? '0 : line_pos + 1'b1;
            // partition finished after its y scan
            if (scan_done && line_done && state == nabp_pkg::addressing_y)
            begin
                part_idx <= part_idx + 1'b1;
                x_off    <= x_off + part_step;
                y_off    <= y_off + col_step;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/pe_stream_register.sv
`default_nettype none

module pe_stream_register
(
    input  wire                  clk,
    input  wire                  reset_n,
    input  wire                  kick,
    input  wire                  pe_enable,
    input  wire nabp_pkg::pe_value_t pe_value,
    output nabp_pkg::pe_beat_t   beat
);

    // payload is captured every cycle, only the strobes are qualified
    always_ff @(posedge clk)
    begin
        beat.value <= pe_value;
    end

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            beat.enable <= 1'b0;
            beat.kick   <= 1'b0;
        end
        else
        begin
            beat.enable <= pe_enable;
            // a sweep cannot start in the middle of a beat
            beat.kick   <= kick & ~pe_enable;
        end
    end

endmodule

`default_nettype wire

// File: verilog/nabp_pkg.sv
`default_nettype none

package nabp_pkg;

    // one back-projected sample from the PE chain
    typedef logic [15:0] pe_value_t;

    // accumulated image word
    // wide enough for the x pass and the y pass of a sweep
    typedef logic [23:0] pixel_t;

    // one registered input beat
    typedef struct packed {
        pe_value_t value;
        logic      enable;
        logic      kick;
    } pe_beat_t;

    // image addresser FSM states
    typedef enum logic [1:0] {
        ready        = 2'd0,
        delay        = 2'd1,
        addressing_x = 2'd2,
        addressing_y = 2'd3
    } addresser_state_t;

endpackage

`default_nettype wire
